//--- verilog/control_pkg.sv
`default_nettype none

package control_pkg;

  typedef logic [3:0] opcode_t;
  typedef logic [5:0] func_t;

  // opcode field
  localparam opcode_t bne_op      = 4'd0;
  localparam opcode_t beq_op      = 4'd1;
  localparam opcode_t bgz_op      = 4'd2;
  localparam opcode_t blz_op      = 4'd3;
  localparam opcode_t adi_op      = 4'd4;
  localparam opcode_t ori_op      = 4'd5;
  localparam opcode_t lhi_op      = 4'd6;
  localparam opcode_t lwd_op      = 4'd7;
  localparam opcode_t swd_op      = 4'd8;
  localparam opcode_t jmp_op      = 4'd9;
  localparam opcode_t jal_op      = 4'd10;
  localparam opcode_t alu_op_code = 4'd15; // r-type, see func_code

  // function field under alu_op_code
  localparam func_t func_add = 6'd0;
  localparam func_t func_sub = 6'd1;
  localparam func_t func_and = 6'd2;
  localparam func_t func_orr = 6'd3;
  localparam func_t func_not = 6'd4;
  localparam func_t func_tcp = 6'd5; // two's complement
  localparam func_t func_shl = 6'd6;
  localparam func_t func_shr = 6'd7;
  localparam func_t func_jpr = 6'd25;
  localparam func_t func_jrl = 6'd26;

  typedef enum logic [2:0] {
    ph_if  = 3'd0,
    ph_ex1 = 3'd1,
    ph_ex2 = 3'd2,
    ph_mem = 3'd3,
    ph_wb  = 3'd4
  } phase_t;

  typedef enum logic [3:0] {
    cls_alu,
    cls_jpr,
    cls_jrl,
    cls_imm,
    cls_lwd,
    cls_swd,
    cls_branch,
    cls_jmp,
    cls_jal,
    cls_invalid
  } instr_class_t;

  typedef struct packed {
    logic mem_write;
    logic mem_read;
    logic reg_write;
    logic reg_dst;          // 1 selects rt as destination
    logic pc_to_reg;        // link value into register file
    logic mem_to_reg;
    logic alu_src_a;
    logic alu_src_b;        // 1 selects the immediate
    logic pc_store;
    logic branch_dst_store;
    logic branch;
    logic jal;
    logic jalr;
    logic pvs_update;       // last phase of an instruction
    logic alu_op;
  } ctrl_word_t;

endpackage

`default_nettype wire

//--- verilog/instr_decoder.sv
`default_nettype none

module instr_decoder (
  input  control_pkg::opcode_t      opcode,
  input  control_pkg::func_t        func_code,
  output control_pkg::instr_class_t instr_class
);

  always_comb begin
    instr_class = control_pkg::cls_invalid; // opcodes 11 to 14 land here
    case (opcode)
      control_pkg::alu_op_code: begin
        case (func_code)
          control_pkg::func_add,
          control_pkg::func_sub,
          control_pkg::func_and,
          control_pkg::func_orr,
          control_pkg::func_not,
          control_pkg::func_tcp,
          control_pkg::func_shl,
          control_pkg::func_shr: begin
            instr_class = control_pkg::cls_alu;
          end
          control_pkg::func_jpr: instr_class = control_pkg::cls_jpr;
          control_pkg::func_jrl: instr_class = control_pkg::cls_jrl;
          default: instr_class = control_pkg::cls_invalid;
        endcase
      end
      control_pkg::adi_op,
      control_pkg::ori_op,
      control_pkg::lhi_op: begin
        instr_class = control_pkg::cls_imm;
      end
      control_pkg::lwd_op: begin
        instr_class = control_pkg::cls_lwd;
      end
      control_pkg::swd_op: begin
        instr_class = control_pkg::cls_swd;
      end
      control_pkg::bne_op,
      control_pkg::beq_op,
      control_pkg::bgz_op,
      control_pkg::blz_op: begin
        instr_class = control_pkg::cls_branch; // condition resolved in datapath
      end
      control_pkg::jmp_op: begin
        instr_class = control_pkg::cls_jmp;
      end
      control_pkg::jal_op: begin
        instr_class = control_pkg::cls_jal;
      end
      default: begin
        instr_class = control_pkg::cls_invalid;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  control_pkg::instr_class_t instr_class,
  output control_pkg::phase_t       phase
);

  control_pkg::phase_t next_phase;

  // true when ph appears in the phase order of cls
  function automatic logic in_order(control_pkg::instr_class_t cls,
                                    control_pkg::phase_t ph);
    logic ok;
    case (cls)
      control_pkg::cls_alu,
      control_pkg::cls_imm:    ok = ph inside {control_pkg::ph_if, control_pkg::ph_ex1,
                                               control_pkg::ph_wb};
      control_pkg::cls_lwd:    ok = ph inside {control_pkg::ph_if, control_pkg::ph_ex1,
                                               control_pkg::ph_mem, control_pkg::ph_wb};
      control_pkg::cls_swd:    ok = ph inside {control_pkg::ph_if, control_pkg::ph_ex1,
                                               control_pkg::ph_mem};
      control_pkg::cls_branch: ok = ph inside {control_pkg::ph_if, control_pkg::ph_ex1,
                                               control_pkg::ph_ex2};
      control_pkg::cls_jpr,
      control_pkg::cls_jmp:    ok = ph inside {control_pkg::ph_if, control_pkg::ph_ex1};
      control_pkg::cls_jrl,
      control_pkg::cls_jal:    ok = ph inside {control_pkg::ph_if, control_pkg::ph_wb};
      default:                 ok = (ph == control_pkg::ph_if);
    endcase
    return ok;
  endfunction

  always_comb begin
    next_phase = control_pkg::ph_if; // final phase and invalid both go back to IF
    case (phase)
      control_pkg::ph_if: begin
        if (instr_class inside {control_pkg::cls_jrl, control_pkg::cls_jal})
          next_phase = control_pkg::ph_wb; // link write needs no execute phase
        else if (instr_class != control_pkg::cls_invalid)
          next_phase = control_pkg::ph_ex1;
      end
      control_pkg::ph_ex1: begin
        if (instr_class inside {control_pkg::cls_alu, control_pkg::cls_imm})
          next_phase = control_pkg::ph_wb;
        else if (instr_class inside {control_pkg::cls_lwd, control_pkg::cls_swd})
          next_phase = control_pkg::ph_mem;
        else if (instr_class == control_pkg::cls_branch)
          next_phase = control_pkg::ph_ex2;
      end
      control_pkg::ph_mem: begin
        if (instr_class == control_pkg::cls_lwd)
          next_phase = control_pkg::ph_wb;
      end
      default: next_phase = control_pkg::ph_if;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      phase <= control_pkg::ph_if;
    else
      phase <= next_phase;
  end

  phase_legal_a: assert property (@(posedge clk) disable iff (!rst_n)
    phase inside {control_pkg::ph_if, control_pkg::ph_ex1, control_pkg::ph_ex2,
                  control_pkg::ph_mem, control_pkg::ph_wb});

  phase_order_a: assert property (@(posedge clk) disable iff (!rst_n)
    (phase != control_pkg::ph_if) |=> in_order($past(instr_class), phase));

endmodule

`default_nettype wire

//--- verilog/control_word_gen.sv
`default_nettype none

module control_word_gen (
  input  control_pkg::instr_class_t instr_class,
  input  control_pkg::phase_t       phase,
  output control_pkg::ctrl_word_t   ctrl
);

  always_comb begin
    ctrl = '0;
    case (instr_class)
      control_pkg::cls_alu: begin
        case (phase)
          control_pkg::ph_if: ctrl.pc_store = 1'b1; // pc+1
          control_pkg::ph_ex1: begin
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          control_pkg::ph_wb: begin
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_jpr: begin
        case (phase)
          control_pkg::ph_if: ctrl.jalr = 1'b1;
          control_pkg::ph_ex1: begin
            ctrl.jalr       = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_jrl: begin
        case (phase)
          control_pkg::ph_if: ctrl.pc_store = 1'b1;
          control_pkg::ph_wb: begin
            ctrl.reg_write  = 1'b1;
            ctrl.pc_to_reg  = 1'b1; // link address
            ctrl.jalr       = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_imm: begin
        case (phase)
          control_pkg::ph_if: ctrl.pc_store = 1'b1;
          control_pkg::ph_ex1: begin
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          control_pkg::ph_wb: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst    = 1'b1;
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_src_b  = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_lwd: begin
        case (phase)
          control_pkg::ph_if: ctrl.pc_store = 1'b1;
          control_pkg::ph_ex1: begin
            ctrl.alu_src_a = 1'b1; // base plus offset
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          control_pkg::ph_mem: begin
            ctrl.mem_read  = 1'b1;
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          control_pkg::ph_wb: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst    = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_swd: begin
        case (phase)
          control_pkg::ph_if: ctrl.pc_store = 1'b1;
          control_pkg::ph_ex1: begin
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_src_b = 1'b1;
            ctrl.alu_op    = 1'b1;
          end
          control_pkg::ph_mem: begin
            ctrl.mem_write  = 1'b1;
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_src_b  = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_branch: begin
        case (phase)
          control_pkg::ph_if: begin
            ctrl.pc_store = 1'b1;
            ctrl.branch   = 1'b1;
          end
          control_pkg::ph_ex1: begin
            ctrl.alu_src_a        = 1'b1; // target address
            ctrl.alu_src_b        = 1'b1;
            ctrl.branch_dst_store = 1'b1;
            ctrl.branch           = 1'b1;
          end
          control_pkg::ph_ex2: begin
            ctrl.alu_src_a  = 1'b1; // condition compare
            ctrl.branch     = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_jmp: begin
        case (phase)
          control_pkg::ph_if: ctrl.jal = 1'b1;
          control_pkg::ph_ex1: begin
            ctrl.jal        = 1'b1;
            ctrl.alu_op     = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      control_pkg::cls_jal: begin
        case (phase)
          control_pkg::ph_if: begin
            ctrl.pc_store = 1'b1;
            ctrl.jal      = 1'b1;
          end
          control_pkg::ph_wb: begin
            ctrl.jal        = 1'b1;
            ctrl.reg_write  = 1'b1; // same link write as jrl
            ctrl.pc_to_reg  = 1'b1;
            ctrl.pvs_update = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      default: ctrl = '0;
    endcase
  end

  mem_rw_excl_a: assert final (!(ctrl.mem_read && ctrl.mem_write));

  pc_src_onehot_a: assert final ($onehot0({ctrl.branch, ctrl.jal, ctrl.jalr}));

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`default_nettype none

module control_unit (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [3:0] opcode,
  input  logic [5:0] func_code,
  output logic       mem_write,
  output logic       mem_read,
  output logic       reg_write,
  output logic       reg_dst,
  output logic       pc_to_reg,
  output logic       mem_to_reg,
  output logic       alu_src_a,
  output logic       alu_src_b,
  output logic       pc_store,
  output logic       branch_dst_store,
  output logic       branch,
  output logic       jal,
  output logic       jalr,
  output logic       pvs_update,
  output logic       alu_op
);

  control_pkg::instr_class_t instr_class;
  control_pkg::phase_t       phase;
  control_pkg::ctrl_word_t   ctrl;

  instr_decoder u_decoder (
    .opcode      (opcode),
    .func_code   (func_code),
    .instr_class (instr_class)
  );

  phase_sequencer u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_class (instr_class),
    .phase       (phase)
  );

  // levels follow phase and opcode in the same cycle
  control_word_gen u_ctrl_gen (
    .instr_class (instr_class),
    .phase       (phase),
    .ctrl        (ctrl)
  );

  assign mem_write        = ctrl.mem_write;
  assign mem_read         = ctrl.mem_read;
  assign reg_write        = ctrl.reg_write;
  assign reg_dst          = ctrl.reg_dst;
  assign pc_to_reg        = ctrl.pc_to_reg;
  assign mem_to_reg       = ctrl.mem_to_reg;
  assign alu_src_a        = ctrl.alu_src_a;
  assign alu_src_b        = ctrl.alu_src_b;
  assign pc_store         = ctrl.pc_store;
  assign branch_dst_store = ctrl.branch_dst_store;
  assign branch           = ctrl.branch;
  assign jal              = ctrl.jal;
  assign jalr             = ctrl.jalr;
  assign pvs_update       = ctrl.pvs_update; // one cycle per instruction
  assign alu_op           = ctrl.alu_op;

endmodule

`default_nettype wire

//--- tb/tb_control_unit.sv
`default_nettype none

module tb_control_unit;

  localparam int cl_alu = 0;
  localparam int cl_jpr = 1;
  localparam int cl_jrl = 2;
  localparam int cl_imm = 3;
  localparam int cl_lwd = 4;
  localparam int cl_swd = 5;
  localparam int cl_br  = 6;
  localparam int cl_jmp = 7;
  localparam int cl_jal = 8;
  localparam int cl_bad = 9;

  localparam int p_if  = 0;
  localparam int p_ex1 = 1;
  localparam int p_mem = 3;

  // one bit per output with mem_write on top
  localparam logic [14:0] m_mw   = 15'h4000;
  localparam logic [14:0] m_mr   = 15'h2000;
  localparam logic [14:0] m_rw   = 15'h1000;
  localparam logic [14:0] m_rd   = 15'h0800;
  localparam logic [14:0] m_ptr  = 15'h0400;
  localparam logic [14:0] m_mtr  = 15'h0200;
  localparam logic [14:0] m_asa  = 15'h0100;
  localparam logic [14:0] m_asb  = 15'h0080;
  localparam logic [14:0] m_pcs  = 15'h0040;
  localparam logic [14:0] m_bds  = 15'h0020;
  localparam logic [14:0] m_br   = 15'h0010;
  localparam logic [14:0] m_jal  = 15'h0008;
  localparam logic [14:0] m_jalr = 15'h0004;
  localparam logic [14:0] m_pvs  = 15'h0002;
  localparam logic [14:0] m_aop  = 15'h0001;

  logic clk = 1'b0;
  logic rst_n;
  logic [3:0] opcode;
  logic [5:0] func_code;
  logic mem_write, mem_read, reg_write, reg_dst, pc_to_reg, mem_to_reg;
  logic alu_src_a, alu_src_b, pc_store, branch_dst_store, branch;
  logic jal, jalr, pvs_update, alu_op;

  logic [31:0] lfsr = 32'h80c3;
  int model_step = 0; // position inside the current instruction
  int test_err = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  control_unit DUT (
    .clk (clk), .rst_n (rst_n), .opcode (opcode), .func_code (func_code),
    .mem_write (mem_write), .mem_read (mem_read), .reg_write (reg_write),
    .reg_dst (reg_dst), .pc_to_reg (pc_to_reg), .mem_to_reg (mem_to_reg),
    .alu_src_a (alu_src_a), .alu_src_b (alu_src_b), .pc_store (pc_store),
    .branch_dst_store (branch_dst_store), .branch (branch), .jal (jal),
    .jalr (jalr), .pvs_update (pvs_update), .alu_op (alu_op)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic int classify(logic [3:0] op, logic [5:0] fn);
    case (op)
      control_pkg::bne_op, control_pkg::beq_op,
      control_pkg::bgz_op, control_pkg::blz_op: return cl_br;
      control_pkg::adi_op, control_pkg::ori_op, control_pkg::lhi_op: return cl_imm;
      control_pkg::lwd_op: return cl_lwd;
      control_pkg::swd_op: return cl_swd;
      control_pkg::jmp_op: return cl_jmp;
      control_pkg::jal_op: return cl_jal;
      control_pkg::alu_op_code: begin
        if (fn <= control_pkg::func_shr) return cl_alu; // add through shr are 0..7
        if (fn == control_pkg::func_jpr) return cl_jpr;
        if (fn == control_pkg::func_jrl) return cl_jrl;
        return cl_bad;
      end
      default: return cl_bad;
    endcase
  endfunction

  function automatic int class_len(int cls);
    case (cls)
      cl_lwd: return 4;
      cl_jpr, cl_jrl, cl_jmp, cl_jal: return 2;
      cl_bad: return 1;
      default: return 3;
    endcase
  endfunction

  // phase of each step as one nibble per step from the bottom
  function automatic int phase_at(int cls, int step);
    logic [15:0] seq;
    case (cls)
      cl_alu, cl_imm: seq = 16'h0410;
      cl_lwd: seq = 16'h4310;
      cl_swd: seq = 16'h0310;
      cl_br: seq = 16'h0210;
      cl_jpr, cl_jmp: seq = 16'h0010;
      cl_jrl, cl_jal: seq = 16'h0040;
      default: seq = 16'h0000;
    endcase
    return int'((seq >> (4 * step)) & 16'h7);
  endfunction

  function automatic logic [14:0] levels(int cls, int ph);
    logic [14:0] v;
    v = '0;
    case (cls)
      cl_alu: begin
        if (ph == p_if) v = m_pcs;
        else if (ph == p_ex1) v = m_asa | m_aop;
        else v = m_rw | m_asa | m_aop | m_pvs;
      end
      cl_jpr: v = (ph == p_if) ? m_jalr : m_jalr | m_pvs;
      cl_jrl: v = (ph == p_if) ? m_pcs : m_rw | m_ptr | m_jalr | m_pvs;
      cl_imm: begin
        if (ph == p_if) v = m_pcs;
        else if (ph == p_ex1) v = m_asa | m_asb | m_aop;
        else v = m_rw | m_rd | m_asa | m_asb | m_aop | m_pvs;
      end
      cl_lwd: begin
        if (ph == p_if) v = m_pcs;
        else if (ph == p_ex1) v = m_asa | m_asb | m_aop;
        else if (ph == p_mem) v = m_mr | m_asa | m_asb | m_aop;
        else v = m_rw | m_rd | m_mtr | m_aop | m_pvs;
      end
      cl_swd: begin
        if (ph == p_if) v = m_pcs;
        else if (ph == p_ex1) v = m_asa | m_asb | m_aop;
        else v = m_mw | m_asa | m_asb | m_aop | m_pvs;
      end
      cl_br: begin
        if (ph == p_if) v = m_pcs | m_br;
        else if (ph == p_ex1) v = m_asa | m_asb | m_bds | m_br;
        else v = m_asa | m_br | m_aop | m_pvs;
      end
      cl_jmp: v = (ph == p_if) ? m_jal : m_jal | m_aop | m_pvs;
      cl_jal: v = (ph == p_if) ? m_pcs | m_jal : m_jal | m_rw | m_ptr | m_pvs;
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic string sig_name(int i);
    case (i)
      0: return "alu_op";
      1: return "pvs_update";
      2: return "jalr";
      3: return "jal";
      4: return "branch";
      5: return "branch_dst_store";
      6: return "pc_store";
      7: return "alu_src_b";
      8: return "alu_src_a";
      9: return "mem_to_reg";
      10: return "pc_to_reg";
      11: return "reg_dst";
      12: return "reg_write";
      13: return "mem_read";
      default: return "mem_write";
    endcase
  endfunction

  function automatic control_pkg::func_t valid_func(int k);
    case (k)
      0: return control_pkg::func_add;
      1: return control_pkg::func_sub;
      2: return control_pkg::func_and;
      3: return control_pkg::func_orr;
      4: return control_pkg::func_not;
      5: return control_pkg::func_tcp;
      6: return control_pkg::func_shl;
      7: return control_pkg::func_shr;
      8: return control_pkg::func_jpr;
      default: return control_pkg::func_jrl;
    endcase
  endfunction

  // model steps alongside the DUT
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      model_step <= 0;
    else if (model_step + 1 >= class_len(classify(opcode, func_code)))
      model_step <= 0;
    else
      model_step <= model_step + 1;
  end

  task automatic get_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic compare_all();
    logic [14:0] exp_v;
    logic [14:0] act_v;
    int cls;
    cls = classify(opcode, func_code);
    exp_v = levels(cls, phase_at(cls, model_step));
    act_v = {mem_write, mem_read, reg_write, reg_dst, pc_to_reg, mem_to_reg, alu_src_a,
             alu_src_b, pc_store, branch_dst_store, branch, jal, jalr, pvs_update, alu_op};
    for (int i = 14; i >= 0; i--) begin
      assert (act_v[i] === exp_v[i]) else begin
        $display("CHECK FAILED t=%0t signal=%s expected=%b actual=%b",
                 $time, sig_name(i), exp_v[i], act_v[i]);
        test_err++;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    compare_all();
  endtask

  task automatic apply(input logic [3:0] op, input logic [5:0] fn);
    opcode = op;
    func_code = fn;
    #5 compare_all(); // IF levels of the new instruction
  endtask

  task automatic run_instr(input logic [3:0] op, input logic [5:0] fn);
    int cycles;
    bit done;
    apply(op, fn);
    cycles = 1;
    done = 0;
    while (!done && cycles < 10) begin
      tick();
      cycles++;
      if (pvs_update) done = 1;
    end
    if (!done) begin
      $display("instruction with opcode %0d and function %0d did not finish in time", op, fn);
      test_err++;
    end else begin
      assert (cycles == class_len(classify(op, fn))) else begin
        $display("CHECK FAILED t=%0t signal=cycles_per_instr expected=%0d actual=%0d",
                 $time, class_len(classify(op, fn)), cycles);
        test_err++;
      end
    end
    tick(); // inputs held through the cycle after pvs_update
  endtask

  task automatic hold_invalid(input logic [3:0] op, input logic [5:0] fn, input int n);
    apply(op, fn);
    for (int k = 0; k < n; k++)
      tick();
  endtask

  // reset in the middle of a load pulls the phase back to IF
  task automatic reset_during_instr();
    apply(control_pkg::lwd_op, 6'd0);
    tick();
    rst_n = 1'b0;
    #5 compare_all();
    repeat (2) tick();
    rst_n = 1'b1;
    run_instr(control_pkg::lwd_op, 6'd0);
  endtask

  task automatic finish_test(input string name);
    if (test_err == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_err);
    end
    test_err = 0;
  endtask

  initial begin
    int op;
    int fn;
    int b;
    rst_n = 1'b0;
    opcode = 4'd11;
    func_code = 6'd0;

    repeat (3) tick();
    rst_n = 1'b1;
    repeat (3) tick();
    reset_during_instr();
    finish_test("reset");

    for (int k = 0; k <= 10; k++)
      run_instr(4'(k), 6'd0);
    for (int k = 0; k < 10; k++)
      run_instr(control_pkg::alu_op_code, valid_func(k));
    finish_test("defined encodings");

    run_instr(control_pkg::alu_op_code, control_pkg::func_add);
    run_instr(control_pkg::alu_op_code, control_pkg::func_jpr);
    run_instr(control_pkg::alu_op_code, control_pkg::func_jrl);
    run_instr(control_pkg::ori_op, 6'd0);
    run_instr(control_pkg::lwd_op, 6'd0);
    run_instr(control_pkg::swd_op, 6'd0);
    run_instr(control_pkg::blz_op, 6'd0);
    run_instr(control_pkg::jmp_op, 6'd0);
    run_instr(control_pkg::jal_op, 6'd0);
    finish_test("instruction length");

    for (int k = 11; k <= 14; k++) begin
      hold_invalid(4'(k), 6'd0, 4);
      run_instr(control_pkg::adi_op, 6'd0);
    end
    hold_invalid(control_pkg::alu_op_code, 6'd8, 4);
    run_instr(control_pkg::lwd_op, 6'd0);
    hold_invalid(control_pkg::alu_op_code, 6'd63, 4);
    run_instr(control_pkg::alu_op_code, control_pkg::func_shr);
    finish_test("undefined encodings");

    for (int n = 0; n < 300; n++) begin
      get_bits(4, op);
      get_bits(1, b);
      if (op == 15 && b == 1) begin
        get_bits(4, fn);
        fn = valid_func(fn % 10);
      end else begin
        get_bits(6, fn);
      end
      if (classify(4'(op), 6'(fn)) == cl_bad) begin
        get_bits(2, b);
        hold_invalid(4'(op), 6'(fn), b + 1);
      end else begin
        run_instr(4'(op), 6'(fn));
      end
    end
    finish_test("random stream");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/control_pkg.sv
verilog/instr_decoder.sv
verilog/phase_sequencer.sv
verilog/control_word_gen.sv
verilog/control_unit.sv
tb/tb_control_unit.sv
